// ==== verification/decode_control_stim.txt ====
# test inst b_equal b_less addr_low, then expected pc_sel flush imm_sel a_sel b_sel
# b_unsigned alu_sel dmem_we sdx_en reg_we wb_sel br_haz store_haz, all hex, one cycle per line
1 00528333 0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0
2 002081b3 0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0
2 402081b3 0 0 0 0 0 0 0 0 0 1 0 0 1 1 0 0
2 002091b3 0 0 0 0 0 0 0 0 0 2 0 0 1 1 0 0
2 0020b1b3 0 0 0 0 0 0 0 0 0 4 0 0 1 1 0 0
2 4020c1b3 0 0 0 0 0 0 0 0 0 5 0 0 1 1 0 0
2 0020d1b3 0 0 0 0 0 0 0 0 0 8 0 0 1 1 0 0
2 4020d1b3 0 0 0 0 0 0 0 0 0 9 0 0 1 1 0 0
2 0020f1b3 0 0 0 0 0 0 0 0 0 7 0 0 1 1 0 0
3 40008193 0 0 0 0 0 1 0 1 0 0 0 0 1 1 0 0
3 0000a193 0 0 0 0 0 1 0 1 0 3 0 0 1 1 0 0
3 4000d193 0 0 0 0 0 1 0 1 0 9 0 0 1 1 0 0
3 0000f193 0 0 0 0 0 1 0 1 0 7 0 0 1 1 0 0
4 123453b7 0 0 0 0 0 4 0 1 0 c 0 0 1 1 0 0
4 00001417 0 0 0 0 0 4 1 1 0 0 0 0 1 1 0 0
4 000000ef 0 0 0 1 1 5 1 1 0 0 0 0 1 2 0 0
4 00108233 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0
4 004202b3 0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0
4 000100e7 0 0 0 1 1 1 0 1 0 0 0 0 1 2 0 0
4 00052483 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0
4 00052483 0 0 0 0 0 1 0 1 0 0 0 0 1 0 0 0
5 00c485b3 0 0 0 0 0 0 3 0 0 0 0 0 1 1 0 0
5 40b706b3 0 0 0 0 0 0 0 2 0 1 0 0 1 1 0 0
5 00d68033 0 0 0 0 0 0 2 2 0 0 0 0 1 1 0 0
5 000007b3 0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0
5 00478813 0 0 0 0 0 1 2 1 0 0 0 0 1 1 0 0
6 01288063 1 0 0 1 1 3 1 1 0 0 0 0 0 0 0 0
6 0020a023 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0
6 01289063 1 0 0 0 0 3 1 1 0 0 0 0 0 0 0 0
6 0128d063 0 0 0 1 1 3 1 1 0 0 0 0 0 0 0 0
6 0020a023 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0
6 0128c063 0 0 0 0 0 3 1 1 0 0 0 0 0 0 0 0
6 0128e063 0 1 0 1 1 3 1 1 1 0 0 0 0 0 0 0
6 002081b3 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0
6 0128f063 0 1 0 0 0 3 1 1 1 0 0 0 0 0 0 0
7 002089b3 0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0
7 01498063 0 0 0 0 0 3 1 1 0 0 0 0 0 0 1 0
7 00208ab3 0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0
7 015a1063 1 0 0 0 0 3 1 1 0 0 0 0 0 0 2 0
7 0000ab03 0 0 0 0 0 1 0 1 0 0 0 0 1 0 0 0
7 014b4063 0 0 0 0 0 3 1 1 0 0 0 0 0 0 3 0
7 0000ab83 0 0 0 0 0 1 0 1 0 0 0 0 1 0 0 0
7 017bd063 0 1 0 0 0 3 1 1 0 0 0 0 0 0 4 0
8 00208023 0 0 0 0 0 2 0 1 0 0 1 1 0 0 0 0
8 00208023 0 0 1 0 0 2 0 1 0 0 2 1 0 0 0 0
8 00208023 0 0 2 0 0 2 0 1 0 0 4 1 0 0 0 0
8 00208023 0 0 3 0 0 2 0 1 0 0 8 1 0 0 0 0
8 00209023 0 0 1 0 0 2 0 1 0 0 3 1 0 0 0 0
8 00209023 0 0 2 0 0 2 0 1 0 0 c 1 0 0 0 0
8 0020a023 0 0 3 0 0 2 0 1 0 0 f 1 0 0 0 0
9 00108113 0 0 0 0 0 1 0 1 0 0 0 0 1 1 0 0
9 0020a023 0 0 1 0 0 2 0 1 0 0 f 1 0 0 0 1
10 00000000 1 1 3 0 0 0 0 0 0 0 0 0 0 1 0 0
10 002081b1 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0
10 0000007f 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0

// ==== list.f ====
design/rv_ctrl_pkg.sv
design/inst_decoder.sv
design/hazard_unit.sv
design/control_merger.sv
design/decode_control.sv
verification/decode_control_properties.sv
verification/decode_control_tb.sv

// ==== Bender.yml ====
package:
  name: decode_control

sources:
  - design/rv_ctrl_pkg.sv
  - design/inst_decoder.sv
  - design/hazard_unit.sv
  - design/control_merger.sv
  - design/decode_control.sv
  - target: test
    files:
      - verification/decode_control_properties.sv
      - verification/decode_control_tb.sv

// ==== verification/decode_control_tb.sv ====
module decode_control_tb;
    import rv_ctrl_pkg::*;

    localparam int    CLK_PERIOD   = 20;
    localparam int    RESET_CYCLES = 3;
    localparam int    MAX_LINES    = 200;   // longest stimulus file accepted
    localparam int    MAX_CYCLES   = 400;
    localparam string STIM_FILE    = "verification/decode_control_stim.txt";

    logic       clk;
    logic       reset;
    inst_t      inst;
    logic       b_equal;
    logic       b_less;
    logic [1:0] addr_low;

    logic       pc_sel;
    logic       flush;
    imm_sel_t   imm_sel;
    opnd_sel_t  a_sel;
    opnd_sel_t  b_sel;
    logic       b_unsigned;
    alu_op_t    alu_sel;
    byte_mask_t dmem_we;
    logic       sdx_en;
    logic       reg_we;
    wb_sel_t    wb_sel;
    br_haz_t    br_haz;
    logic       store_haz;

    int err_count;
    int test_errs;
    int tests_run;
    int tests_failed;

    decode_control decode_control_i (
        .clk        (clk),
        .reset      (reset),
        .inst       (inst),
        .b_equal    (b_equal),
        .b_less     (b_less),
        .addr_low   (addr_low),
        .pc_sel     (pc_sel),
        .flush      (flush),
        .imm_sel    (imm_sel),
        .a_sel      (a_sel),
        .b_sel      (b_sel),
        .b_unsigned (b_unsigned),
        .alu_sel    (alu_sel),
        .dmem_we    (dmem_we),
        .sdx_en     (sdx_en),
        .reg_we     (reg_we),
        .wb_sel     (wb_sel),
        .br_haz     (br_haz),
        .store_haz  (store_haz)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // watchdog
    initial begin
        for (int cyc = 0; cyc < MAX_CYCLES; cyc++) begin
            @(posedge clk);
        end
        $display("simulation still running after %0d cycles", MAX_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("error %s expected %0h got %0h", name, exp, got);
        test_errs++;
    endtask

    task automatic check_sel(input string name, input opnd_sel_t exp, input opnd_sel_t got);
        if (got !== exp) report_mismatch(name, 32'(exp), 32'(got));
    endtask

    task automatic check_mask(input string name, input byte_mask_t exp, input byte_mask_t got);
        if (got !== exp) report_mismatch(name, 32'(exp), 32'(got));
    endtask

    task automatic check_alu(input string name, input alu_op_t exp, input alu_op_t got);
        if (got !== exp) report_mismatch(name, 32'(exp), 32'(got));
    endtask

    task automatic check_imm(input string name, input imm_sel_t exp, input imm_sel_t got);
        if (got !== exp) report_mismatch(name, 32'(exp), 32'(got));
    endtask

    task automatic check_wb(input string name, input wb_sel_t exp, input wb_sel_t got);
        if (got !== exp) report_mismatch(name, 32'(exp), 32'(got));
    endtask

    task automatic check_haz(input string name, input br_haz_t exp, input br_haz_t got);
        if (got !== exp) report_mismatch(name, 32'(exp), 32'(got));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) report_mismatch(name, 32'(exp), 32'(got));
    endtask

    task automatic compare_outputs(
        input logic       e_pc_sel,
        input logic       e_flush,
        input imm_sel_t   e_imm_sel,
        input opnd_sel_t  e_a_sel,
        input opnd_sel_t  e_b_sel,
        input logic       e_b_unsigned,
        input alu_op_t    e_alu_sel,
        input byte_mask_t e_dmem_we,
        input logic       e_sdx_en,
        input logic       e_reg_we,
        input wb_sel_t    e_wb_sel,
        input br_haz_t    e_br_haz,
        input logic       e_store_haz
    );
        check_bit("pc_sel", e_pc_sel, pc_sel);
        check_bit("flush", e_flush, flush);
        check_imm("imm_sel", e_imm_sel, imm_sel);
        check_sel("a_sel", e_a_sel, a_sel);
        check_sel("b_sel", e_b_sel, b_sel);
        check_bit("b_unsigned", e_b_unsigned, b_unsigned);
        check_alu("alu_sel", e_alu_sel, alu_sel);
        check_mask("dmem_we", e_dmem_we, dmem_we);
        check_bit("sdx_en", e_sdx_en, sdx_en);
        check_bit("reg_we", e_reg_we, reg_we);
        check_wb("wb_sel", e_wb_sel, wb_sel);
        check_haz("br_haz", e_br_haz, br_haz);
        check_bit("store_haz", e_store_haz, store_haz);
    endtask

    task automatic finish_test(input int num);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %0d passed", num);
        end else begin
            $display("test %0d failed with %0d errors", num, test_errs);
            tests_failed++;
        end
        err_count += test_errs;
        test_errs = 0;
    endtask

    // outputs settle before the next edge
    task automatic drive_inputs(input logic rst, input inst_t word, input logic eq,
                                input logic lt, input logic [1:0] low);
        @(posedge clk);
        reset    <= rst;
        inst     <= word;
        b_equal  <= eq;
        b_less   <= lt;
        addr_low <= low;
        #(CLK_PERIOD - 1);
    endtask

    initial begin
        int         fd;
        int         line_count;
        int         fields;
        int         cur_test;
        string      line;
        int         s_test;
        inst_t      s_inst;
        logic       s_eq;
        logic       s_lt;
        logic [1:0] s_low;
        logic       e_pc;
        logic       e_flush;
        imm_sel_t   e_imm;
        opnd_sel_t  e_a;
        opnd_sel_t  e_b;
        logic       e_bu;
        alu_op_t    e_alu;
        byte_mask_t e_dm;
        logic       e_sdx;
        logic       e_rwe;
        wb_sel_t    e_wb;
        br_haz_t    e_brh;
        logic       e_sth;
        reset = 1'b1;
        inst = '0;
        b_equal = 1'b0;
        b_less = 1'b0;
        addr_low = '0;
        err_count = 0;
        test_errs = 0;
        tests_run = 0;
        tests_failed = 0;

        // jal x5 held in decode during reset comes out as a bubble
        for (int i = 0; i < RESET_CYCLES; i++) begin
            drive_inputs(1'b1, 32'h000002ef, 1'b1, 1'b1, 2'd0);
            compare_outputs(1'b0, 1'b0, '0, SEL_REG, SEL_REG, 1'b0, ALU_ADD, '0, 1'b0, 1'b0,
                            WB_ALU, BR_NONE, 1'b0);
        end
        finish_test(0);

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open stimulus file %s", STIM_FILE);
            err_count++;
        end
        cur_test = -1;
        line_count = 0;
        while (fd != 0 && !$feof(fd) && line_count < MAX_LINES) begin
            line_count++;
            line = "";
            if ($fgets(line, fd) > 0 && line[0] != "#" && line[0] != "\n") begin
                fields = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                 s_test, s_inst, s_eq, s_lt, s_low, e_pc, e_flush, e_imm, e_a,
                                 e_b, e_bu, e_alu, e_dm, e_sdx, e_rwe, e_wb, e_brh, e_sth);
                if (fields != 18) begin
                    $display("stimulus line %0d could not be parsed", line_count);
                    err_count++;
                end else begin
                    if (s_test != cur_test) begin
                        if (cur_test >= 0) finish_test(cur_test);
                        cur_test = s_test;
                    end
                    drive_inputs(1'b0, s_inst, s_eq, s_lt, s_low);
                    compare_outputs(e_pc, e_flush, e_imm, e_a, e_b, e_bu, e_alu, e_dm, e_sdx,
                                    e_rwe, e_wb, e_brh, e_sth);
                end
            end
        end
        if (fd != 0) begin
            if (!$feof(fd)) begin
                $display("stimulus file has more than %0d lines", MAX_LINES);
                err_count++;
            end
            $fclose(fd);
        end
        if (cur_test >= 0) begin
            finish_test(cur_test);
        end else begin
            $display("no stimulus lines were read");
            err_count++;
        end

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== verification/decode_control_properties.sv ====
module decode_control_properties (
    input logic                    clk,
    input logic                    reset,
    input logic                    pc_sel,
    input logic                    flush,
    input logic                    reg_we,
    input logic                    sdx_en,
    input rv_ctrl_pkg::byte_mask_t dmem_we
);

    reset_quiet: assert property (@(posedge clk) reset |-> !reg_we && !pc_sel && dmem_we == '0)
        else $error("reg_we, dmem_we or pc_sel active during reset");

    // slot after a redirect is a bubble
    flush_bubble: assert property (@(posedge clk) flush |=> !reg_we && dmem_we == '0)
        else $error("instruction after a flush still writes");

    mask_has_data: assert property (@(posedge clk) dmem_we != '0 |-> sdx_en)
        else $error("byte mask set without store data enable");

endmodule

bind decode_control decode_control_properties decode_control_properties_i (
    .clk     (clk),
    .reset   (reset),
    .pc_sel  (pc_sel),
    .flush   (flush),
    .reg_we  (reg_we),
    .sdx_en  (sdx_en),
    .dmem_we (dmem_we)
);

// ==== design/decode_control.sv ====
module decode_control (
    input  logic                    clk,
    input  logic                    reset,
    input  rv_ctrl_pkg::inst_t      inst,
    input  logic                    b_equal,
    input  logic                    b_less,
    input  logic [1:0]              addr_low,   // low bits of the alu address
    output logic                    pc_sel,
    output logic                    flush,
    output rv_ctrl_pkg::imm_sel_t   imm_sel,
    output rv_ctrl_pkg::opnd_sel_t  a_sel,
    output rv_ctrl_pkg::opnd_sel_t  b_sel,
    output logic                    b_unsigned,
    output rv_ctrl_pkg::alu_op_t    alu_sel,
    output rv_ctrl_pkg::byte_mask_t dmem_we,
    output logic                    sdx_en,
    output logic                    reg_we,
    output rv_ctrl_pkg::wb_sel_t    wb_sel,
    output rv_ctrl_pkg::br_haz_t    br_haz,
    output logic                    store_haz
);
    import rv_ctrl_pkg::*;

    logic       dec_pc_sel;
    logic       dec_flush;
    imm_sel_t   dec_imm_sel;
    opnd_sel_t  a_base;
    opnd_sel_t  b_base;
    logic       dec_b_unsigned;
    alu_op_t    dec_alu_sel;
    byte_mask_t dec_dmem_we;
    logic       dec_sdx_en;
    logic       reg_we_base;
    wb_sel_t    dec_wb_sel;
    logic       is_branch;
    logic       is_store;
    fwd_t       fwd_a;
    fwd_t       fwd_b;
    br_haz_t    haz_br;
    logic       haz_store;

    inst_decoder inst_decoder_i (
        .inst        (inst),
        .b_equal     (b_equal),
        .b_less      (b_less),
        .addr_low    (addr_low),
        .pc_sel      (dec_pc_sel),
        .flush       (dec_flush),
        .imm_sel     (dec_imm_sel),
        .a_base      (a_base),
        .b_base      (b_base),
        .b_unsigned  (dec_b_unsigned),
        .alu_sel     (dec_alu_sel),
        .dmem_we     (dec_dmem_we),
        .sdx_en      (dec_sdx_en),
        .reg_we_base (reg_we_base),
        .wb_sel      (dec_wb_sel),
        .is_branch   (is_branch),
        .is_store    (is_store)
    );

    // history tracks the final write enable, not the decoded one
    hazard_unit hazard_unit_i (
        .clk       (clk),
        .reset     (reset),
        .inst      (inst),
        .reg_we    (reg_we),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b),
        .br_haz    (haz_br),
        .store_haz (haz_store)
    );

    control_merger control_merger_i (
        .clk            (clk),
        .reset          (reset),
        .dec_pc_sel     (dec_pc_sel),
        .dec_flush      (dec_flush),
        .dec_imm_sel    (dec_imm_sel),
        .a_base         (a_base),
        .b_base         (b_base),
        .dec_b_unsigned (dec_b_unsigned),
        .dec_alu_sel    (dec_alu_sel),
        .dec_dmem_we    (dec_dmem_we),
        .dec_sdx_en     (dec_sdx_en),
        .reg_we_base    (reg_we_base),
        .dec_wb_sel     (dec_wb_sel),
        .is_branch      (is_branch),
        .is_store       (is_store),
        .fwd_a          (fwd_a),
        .fwd_b          (fwd_b),
        .haz_br         (haz_br),
        .haz_store      (haz_store),
        .pc_sel         (pc_sel),
        .flush          (flush),
        .imm_sel        (imm_sel),
        .a_sel          (a_sel),
        .b_sel          (b_sel),
        .b_unsigned     (b_unsigned),
        .alu_sel        (alu_sel),
        .dmem_we        (dmem_we),
        .sdx_en         (sdx_en),
        .reg_we         (reg_we),
        .wb_sel         (wb_sel),
        .br_haz         (br_haz),
        .store_haz      (store_haz)
    );

endmodule

// ==== design/control_merger.sv ====
module control_merger (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    dec_pc_sel,
    input  logic                    dec_flush,
    input  rv_ctrl_pkg::imm_sel_t   dec_imm_sel,
    input  rv_ctrl_pkg::opnd_sel_t  a_base,
    input  rv_ctrl_pkg::opnd_sel_t  b_base,
    input  logic                    dec_b_unsigned,
    input  rv_ctrl_pkg::alu_op_t    dec_alu_sel,
    input  rv_ctrl_pkg::byte_mask_t dec_dmem_we,
    input  logic                    dec_sdx_en,
    input  logic                    reg_we_base,
    input  rv_ctrl_pkg::wb_sel_t    dec_wb_sel,
    input  logic                    is_branch,
    input  logic                    is_store,
    input  rv_ctrl_pkg::fwd_t       fwd_a,
    input  rv_ctrl_pkg::fwd_t       fwd_b,
    input  rv_ctrl_pkg::br_haz_t    haz_br,
    input  logic                    haz_store,
    output logic                    pc_sel,
    output logic                    flush,
    output rv_ctrl_pkg::imm_sel_t   imm_sel,
    output rv_ctrl_pkg::opnd_sel_t  a_sel,
    output rv_ctrl_pkg::opnd_sel_t  b_sel,
    output logic                    b_unsigned,
    output rv_ctrl_pkg::alu_op_t    alu_sel,
    output rv_ctrl_pkg::byte_mask_t dmem_we,
    output logic                    sdx_en,
    output logic                    reg_we,
    output rv_ctrl_pkg::wb_sel_t    wb_sel,
    output rv_ctrl_pkg::br_haz_t    br_haz,
    output logic                    store_haz
);
    import rv_ctrl_pkg::*;

    logic squash_pending; // instruction in decode follows a taken jump/branch

    // only register operands can be replaced by a forwarded value
    function automatic opnd_sel_t apply_fwd(input opnd_sel_t base, input fwd_t fwd);
        opnd_sel_t sel;
        sel = base;
        if (base == SEL_REG) begin
            if (fwd == FWD_ALU) sel = SEL_ALU_FWD;
            else if (fwd == FWD_MEM) sel = SEL_MEM_FWD;
        end
        return sel;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) squash_pending <= 1'b0;
        else squash_pending <= flush;
    end

    always_comb begin
        pc_sel     = dec_pc_sel;
        flush      = dec_flush;
        imm_sel    = dec_imm_sel;
        a_sel      = apply_fwd(a_base, fwd_a);
        b_sel      = apply_fwd(b_base, fwd_b);
        b_unsigned = dec_b_unsigned;
        alu_sel    = dec_alu_sel;
        dmem_we    = dec_dmem_we;
        sdx_en     = dec_sdx_en;
        reg_we     = reg_we_base;
        wb_sel     = dec_wb_sel;
        br_haz     = is_branch ? haz_br : BR_NONE;
        store_haz  = is_store && haz_store;
        if (squash_pending || reset) begin
            // bubble
            pc_sel     = 1'b0;
            flush      = 1'b0;
            imm_sel    = '0;
            a_sel      = SEL_REG;
            b_sel      = SEL_REG;
            b_unsigned = 1'b0;
            alu_sel    = ALU_ADD;
            dmem_we    = '0;
            sdx_en     = 1'b0;
            reg_we     = 1'b0;
            wb_sel     = WB_ALU;
            br_haz     = BR_NONE;
            store_haz  = 1'b0;
        end
    end

endmodule

// ==== design/hazard_unit.sv ====
module hazard_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  rv_ctrl_pkg::inst_t   inst,
    input  logic                 reg_we,
    output rv_ctrl_pkg::fwd_t    fwd_a,
    output rv_ctrl_pkg::fwd_t    fwd_b,
    output rv_ctrl_pkg::br_haz_t br_haz,
    output logic                 store_haz
);
    import rv_ctrl_pkg::*;

    reg_addr_t rs1;
    reg_addr_t rs2;
    opcode_t   opcode;
    logic      match_a;
    logic      match_b;

    // history of the instruction one stage ahead
    reg_addr_t prev_rd;
    logic      prev_load;
    logic      prev_we;

    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign opcode = inst[6:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_rd   <= '0;
            prev_load <= 1'b0;
            prev_we   <= 1'b0;
        end else begin
            prev_rd   <= inst[11:7];
            prev_load <= (opcode == OPC_LOAD);
            prev_we   <= reg_we; // final reg_we keeps squashed slots from forwarding
        end
    end

    assign match_a = prev_we && (rs1 == prev_rd) && (rs1 != '0);
    assign match_b = prev_we && (rs2 == prev_rd) && (rs2 != '0);

    // load data arrives from the memory path, everything else from the alu
    assign fwd_a = !match_a ? FWD_NONE : (prev_load ? FWD_MEM : FWD_ALU);
    assign fwd_b = !match_b ? FWD_NONE : (prev_load ? FWD_MEM : FWD_ALU);

    always_comb begin
        if (match_b) begin         // rs2 takes priority
            br_haz = prev_load ? BR_MEM_B : BR_ALU_B;
        end else if (match_a) begin
            br_haz = prev_load ? BR_MEM_A : BR_ALU_A;
        end else begin
            br_haz = BR_NONE;
        end
    end

    assign store_haz = match_b; // store data depends on the previous result

endmodule

// ==== design/inst_decoder.sv ====
module inst_decoder (
    input  rv_ctrl_pkg::inst_t      inst,
    input  logic                    b_equal,
    input  logic                    b_less,
    input  logic [1:0]              addr_low,
    output logic                    pc_sel,
    output logic                    flush,
    output rv_ctrl_pkg::imm_sel_t   imm_sel,
    output rv_ctrl_pkg::opnd_sel_t  a_base,
    output rv_ctrl_pkg::opnd_sel_t  b_base,
    output logic                    b_unsigned,
    output rv_ctrl_pkg::alu_op_t    alu_sel,
    output rv_ctrl_pkg::byte_mask_t dmem_we,
    output logic                    sdx_en,
    output logic                    reg_we_base,
    output rv_ctrl_pkg::wb_sel_t    wb_sel,
    output logic                    is_branch,
    output logic                    is_store
);
    import rv_ctrl_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    logic    taken;

    assign opcode = inst[6:2];
    assign funct3 = inst[14:12];

    // alt selects SUB for add, SRA for shift right
    function automatic alu_op_t alu_op(input funct3_t f3, input logic alt_add,
                                       input logic alt_shift);
        alu_op_t op;
        case (f3)
            FNC_ADD_SUB: op = alt_add ? ALU_SUB : ALU_ADD;
            FNC_SLL:     op = ALU_SLL;
            FNC_SLT:     op = ALU_SLT;
            FNC_SLTU:    op = ALU_SLTU;
            FNC_XOR:     op = ALU_XOR;
            FNC_SRL_SRA: op = alt_shift ? ALU_SRA : ALU_SRL;
            FNC_OR:      op = ALU_OR;
            default:     op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        case (funct3)
            FNC_BEQ:             taken = b_equal;
            FNC_BNE:             taken = !b_equal;
            FNC_BLT, FNC_BLTU:   taken = b_less;
            FNC_BGE, FNC_BGEU:   taken = !b_less;
            default:             taken = 1'b0; // reserved encodings never branch
        endcase
    end

    always_comb begin
        pc_sel      = 1'b0;
        flush       = 1'b0;
        imm_sel     = '0;
        a_base      = SEL_REG;
        b_base      = SEL_REG;
        b_unsigned  = 1'b0;
        alu_sel     = ALU_ADD;
        dmem_we     = '0;
        sdx_en      = 1'b0;
        reg_we_base = 1'b0;
        wb_sel      = WB_ALU;
        is_branch   = 1'b0;
        is_store    = 1'b0;
        if (inst[1:0] == 2'b11) begin // 16-bit encodings stay a bubble
            case (opcode)
                OPC_LUI: begin
                    imm_sel = IMM_U;
                    b_base = SEL_IMM_PC;
                    alu_sel = ALU_COPY_B;
                    reg_we_base = 1'b1;
                end
                OPC_AUIPC: begin
                    imm_sel = IMM_U;
                    a_base = SEL_IMM_PC;
                    b_base = SEL_IMM_PC;
                    reg_we_base = 1'b1;
                end
                OPC_JAL, OPC_JALR: begin
                    pc_sel = 1'b1;
                    flush = 1'b1;
                    imm_sel = (opcode == OPC_JAL) ? IMM_J : IMM_I;
                    a_base = (opcode == OPC_JAL) ? SEL_IMM_PC : SEL_REG;
                    b_base = SEL_IMM_PC;
                    reg_we_base = 1'b1;
                    wb_sel = WB_PC4; // link address
                end
                OPC_BRANCH: begin
                    pc_sel = taken;
                    flush = taken;
                    imm_sel = IMM_B;
                    a_base = SEL_IMM_PC; // target is pc + imm
                    b_base = SEL_IMM_PC;
                    b_unsigned = (funct3 == FNC_BLTU) || (funct3 == FNC_BGEU);
                    wb_sel = WB_MEM;
                    is_branch = 1'b1;
                end
                OPC_STORE: begin
                    imm_sel = IMM_S;
                    b_base = SEL_IMM_PC;
                    sdx_en = 1'b1;
                    wb_sel = WB_MEM;
                    is_store = 1'b1;
                    case (funct3)
                        FNC_SW:  dmem_we = 4'b1111;
                        FNC_SH:  dmem_we = (addr_low < 2'd2) ? 4'b0011 : 4'b1100;
                        FNC_SB:  dmem_we = 4'b0001 << addr_low;
                        default: dmem_we = 4'b0000;
                    endcase
                end
                OPC_LOAD: begin
                    imm_sel = IMM_I;
                    b_base = SEL_IMM_PC;
                    reg_we_base = 1'b1;
                    wb_sel = WB_MEM;
                end
                OPC_ARI_R: begin
                    alu_sel = alu_op(funct3, inst[30], inst[30]);
                    reg_we_base = 1'b1;
                end
                OPC_ARI_I: begin
                    imm_sel = IMM_I;
                    b_base = SEL_IMM_PC;
                    alu_sel = alu_op(funct3, 1'b0, inst[30]); // no subi
                    reg_we_base = 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== design/rv_ctrl_pkg.sv ====
package rv_ctrl_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  opcode_t;    // inst[6:2]
    typedef logic [2:0]  funct3_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [2:0]  imm_sel_t;
    typedef logic [1:0]  opnd_sel_t;
    typedef logic [1:0]  fwd_t;
    typedef logic [1:0]  wb_sel_t;
    typedef logic [2:0]  br_haz_t;
    typedef logic [3:0]  byte_mask_t;

    // major opcodes with the low two bits stripped
    localparam opcode_t OPC_LUI    = 5'b01101;
    localparam opcode_t OPC_AUIPC  = 5'b00101;
    localparam opcode_t OPC_JAL    = 5'b11011;
    localparam opcode_t OPC_JALR   = 5'b11001;
    localparam opcode_t OPC_BRANCH = 5'b11000;
    localparam opcode_t OPC_STORE  = 5'b01000;
    localparam opcode_t OPC_LOAD   = 5'b00000;
    localparam opcode_t OPC_ARI_R  = 5'b01100;
    localparam opcode_t OPC_ARI_I  = 5'b00100;

    localparam funct3_t FNC_BEQ  = 3'b000;
    localparam funct3_t FNC_BNE  = 3'b001;
    localparam funct3_t FNC_BLT  = 3'b100;
    localparam funct3_t FNC_BGE  = 3'b101;
    localparam funct3_t FNC_BLTU = 3'b110;
    localparam funct3_t FNC_BGEU = 3'b111;

    localparam funct3_t FNC_SB = 3'b000;
    localparam funct3_t FNC_SH = 3'b001;
    localparam funct3_t FNC_SW = 3'b010;

    localparam funct3_t FNC_ADD_SUB = 3'b000;
    localparam funct3_t FNC_SLL     = 3'b001;
    localparam funct3_t FNC_SLT     = 3'b010;
    localparam funct3_t FNC_SLTU    = 3'b011;
    localparam funct3_t FNC_XOR     = 3'b100;
    localparam funct3_t FNC_SRL_SRA = 3'b101;
    localparam funct3_t FNC_OR      = 3'b110;
    localparam funct3_t FNC_AND     = 3'b111;

    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_SLL    = 4'd2;
    localparam alu_op_t ALU_SLT    = 4'd3;
    localparam alu_op_t ALU_SLTU   = 4'd4;
    localparam alu_op_t ALU_XOR    = 4'd5;
    localparam alu_op_t ALU_OR     = 4'd6;
    localparam alu_op_t ALU_AND    = 4'd7;
    localparam alu_op_t ALU_SRL    = 4'd8;
    localparam alu_op_t ALU_SRA    = 4'd9;
    localparam alu_op_t ALU_COPY_B = 4'd12;

    localparam imm_sel_t IMM_I = 3'd1;
    localparam imm_sel_t IMM_S = 3'd2;
    localparam imm_sel_t IMM_B = 3'd3;
    localparam imm_sel_t IMM_U = 3'd4;
    localparam imm_sel_t IMM_J = 3'd5;

    localparam opnd_sel_t SEL_REG     = 2'd0;
    localparam opnd_sel_t SEL_IMM_PC  = 2'd1; // imm for B, pc for A
    localparam opnd_sel_t SEL_ALU_FWD = 2'd2;
    localparam opnd_sel_t SEL_MEM_FWD = 2'd3;

    localparam fwd_t FWD_NONE = 2'd0;
    localparam fwd_t FWD_ALU  = 2'd1;
    localparam fwd_t FWD_MEM  = 2'd2;

    localparam wb_sel_t WB_MEM = 2'd0;
    localparam wb_sel_t WB_ALU = 2'd1;
    localparam wb_sel_t WB_PC4 = 2'd2;

    localparam br_haz_t BR_NONE  = 3'd0;
    localparam br_haz_t BR_ALU_A = 3'd1;
    localparam br_haz_t BR_ALU_B = 3'd2;
    localparam br_haz_t BR_MEM_A = 3'd3;
    localparam br_haz_t BR_MEM_B = 3'd4;

endpackage
